// ==== Bender.yml ====
package:
  name: keypad_display

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/keypad_display_pkg.sv
      - hdl/key_capture.sv
      - hdl/digit_entry.sv
      - hdl/segment_scanner.sv
      - hdl/keypad_display_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/keypad_display_tb.sv

// ==== hdl/digit_entry.sv ====
`timescale 1ns/1ns
`include "keypad_display_settings.svh"

module digit_entry (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          key_valid,
    input  keypad_display_pkg::key_code_t key_code,
    output logic                          commit,
    output keypad_display_pkg::frame_t    frame
);
    import keypad_display_pkg::*;

    localparam int CUR_W = $clog2(`KD_NUM_DIGITS);

    frame_t           working;
    logic [CUR_W-1:0] cursor;
    logic             is_digit;
    seg_t             pattern;

    function automatic seg_t encode(input key_code_t code);
        seg_t pat;
        case (code)
            4'd0:    pat = 7'b0110000; // 1
            4'd1:    pat = 7'b1101101; // 2
            4'd2:    pat = 7'b1111001; // 3
            4'd3:    pat = 7'b0110011; // 4
            4'd4:    pat = 7'b1011011; // 5
            4'd5:    pat = 7'b1011111; // 6
            4'd6:    pat = 7'b1110010; // 7
            4'd7:    pat = 7'b1111111; // 8
            4'd8:    pat = 7'b1111011; // 9
            4'd9:    pat = 7'b1111110; // 0
            default: pat = 7'b0000000;
        endcase
        return pat;
    endfunction

    assign is_digit = (key_code < KEY_STAR); // codes below star are digits
    assign pattern  = encode(key_code);
    assign frame    = working;

    always_ff @(posedge clk) begin
        if (!rst) begin
            working <= '0;
            cursor  <= '0;
            commit  <= 1'b0;
        end else begin
            commit <= key_valid && (key_code == KEY_STAR);
            if (key_valid) begin
                if (is_digit) begin
                    working[cursor] <= pattern; // cursor stays put
                end else if (key_code == KEY_HASH) begin
                    if (cursor == CUR_W'(`KD_NUM_DIGITS - 1)) begin
                        cursor <= '0;
                    end else begin
                        cursor <= cursor + 1'b1;
                    end
                end
            end
        end
    end

    // relies on the capture never issuing back-to-back events
    assert property (@(posedge clk) disable iff (!rst) commit |=> !commit)
        else $error("commit held for two cycles");

endmodule

// ==== hdl/key_capture.sv ====
`timescale 1ns/1ns
`include "keypad_display_settings.svh"

module key_capture (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [11:0]                   keys,
    output logic                          key_valid,
    output keypad_display_pkg::key_code_t key_code
);
    import keypad_display_pkg::*;

    logic [11:0] sync_q [`KD_SYNC_STAGES];
    logic [11:0] keys_s;
    logic        armed;
    logic        one_hot;
    key_code_t   code_d;

    assign keys_s  = sync_q[`KD_SYNC_STAGES-1];
    assign one_hot = (keys_s != '0) && ((keys_s & (keys_s - 12'd1)) == '0);

    always_comb begin
        code_d = '0;
        for (int i = 0; i < 12; i++) begin
            if (keys_s[i]) begin
                code_d = key_code_t'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int s = 0; s < `KD_SYNC_STAGES; s++) begin
                sync_q[s] <= '0;
            end
            armed     <= 1'b1;
            key_valid <= 1'b0;
        end else begin
            sync_q[0] <= keys; // async key lines
            for (int s = 1; s < `KD_SYNC_STAGES; s++) begin
                sync_q[s] <= sync_q[s-1];
            end
            armed     <= (keys_s == '0); // only full release re-arms
            key_valid <= armed && one_hot;
        end
    end

    always_ff @(posedge clk) begin
        if (armed && one_hot) begin
            key_code <= code_d;
        end
    end

    assert property (@(posedge clk) disable iff (!rst) key_valid |=> !key_valid)
        else $error("key_valid held for two cycles");

    // also keeps key_code below 12
    assert property (@(posedge clk) disable iff (!rst)
        key_valid |-> $past(keys_s) == (12'd1 << key_code))
        else $error("key_code does not match the pressed key");

endmodule

// ==== hdl/keypad_display_pkg.sv ====
`include "keypad_display_settings.svh"

package keypad_display_pkg;

    // key index with 0..8 for digits 1..9 and 9 for digit 0
    typedef logic [3:0] key_code_t;

    localparam key_code_t KEY_STAR = 4'd10; // commit
    localparam key_code_t KEY_HASH = 4'd11; // cursor step

    // active high segments a (msb) down to g
    typedef logic [6:0] seg_t;

    // slot 0 is the rightmost digit
    typedef seg_t [`KD_NUM_DIGITS-1:0] frame_t;

endpackage

// ==== hdl/keypad_display_settings.svh ====
`ifndef KEYPAD_DISPLAY_SETTINGS_SVH
`define KEYPAD_DISPLAY_SETTINGS_SVH

// number of seven-segment digits on the display
`define KD_NUM_DIGITS 8

// clock cycles each digit stays selected
`define KD_SCAN_DIVIDE 4

// flops in the key line synchronizer
`define KD_SYNC_STAGES 2

`endif

// ==== hdl/keypad_display_top.sv ====
`timescale 1ns/1ns

module keypad_display_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [11:0]              keys,
    output logic [7:0]               digit_sel,
    output keypad_display_pkg::seg_t seg_data
);
    import keypad_display_pkg::*;

    logic      key_valid;
    key_code_t key_code;
    logic      commit;
    frame_t    frame;

    // raw keypad lines to single press events
    key_capture u_key_capture (
        .clk       (clk),
        .rst       (rst),
        .keys      (keys),
        .key_valid (key_valid),
        .key_code  (key_code)
    );

    digit_entry u_digit_entry (
        .clk       (clk),
        .rst       (rst),
        .key_valid (key_valid),
        .key_code  (key_code),
        .commit    (commit),
        .frame     (frame)
    );

    // multiplexed display drive
    segment_scanner u_segment_scanner (
        .clk       (clk),
        .rst       (rst),
        .commit    (commit),
        .frame     (frame),
        .digit_sel (digit_sel),
        .seg_data  (seg_data)
    );

endmodule

// ==== hdl/segment_scanner.sv ====
`timescale 1ns/1ns
`include "keypad_display_settings.svh"

module segment_scanner (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       commit,
    input  keypad_display_pkg::frame_t frame,
    output logic [7:0]                 digit_sel,
    output keypad_display_pkg::seg_t   seg_data
);
    import keypad_display_pkg::*;

    localparam int PRE_W = $clog2(`KD_SCAN_DIVIDE);
    localparam int DIG_W = $clog2(`KD_NUM_DIGITS);

    frame_t           shown;
    logic [PRE_W-1:0] pre_cnt;
    logic             tick;
    logic [DIG_W-1:0] digit;
    logic [DIG_W-1:0] next_digit;
    logic             started;

    assign tick = (pre_cnt == PRE_W'(`KD_SCAN_DIVIDE - 1));

    always_comb begin
        if (!started) begin
            next_digit = '0; // first selection after reset
        end else if (digit == DIG_W'(`KD_NUM_DIGITS - 1)) begin
            next_digit = '0;
        end else begin
            next_digit = digit + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            shown <= '0; // blank display
        end else if (commit) begin
            shown <= frame;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            pre_cnt   <= '0;
            digit     <= '0;
            started   <= 1'b0;
            digit_sel <= '0;
            seg_data  <= '0;
        end else begin
            pre_cnt <= tick ? '0 : pre_cnt + 1'b1;
            if (tick) begin
                started   <= 1'b1;
                digit     <= next_digit;
                digit_sel <= 8'd1 << next_digit; // select and pattern move together
                seg_data  <= shown[next_digit];
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst) $onehot0(digit_sel))
        else $error("more than one digit selected");

endmodule

// ==== keypad_display.f ====
+incdir+hdl
hdl/keypad_display_pkg.sv
hdl/key_capture.sv
hdl/digit_entry.sv
hdl/segment_scanner.sv
hdl/keypad_display_top.sv
testbench/keypad_display_tb.sv

// ==== testbench/keypad_display_tb.sv ====
`timescale 1ns/1ns
`include "keypad_display_settings.svh"

module keypad_display_tb;
    import keypad_display_pkg::*;

    localparam int NUM_RANDOM    = 200;
    localparam int SCAN_CYCLES   = `KD_NUM_DIGITS * `KD_SCAN_DIVIDE;
    localparam int SETTLE_CYCLES = 2 * SCAN_CYCLES + 8;
    localparam int NUM_PRESSES   = NUM_RANDOM + 40; // random plus directed bursts
    localparam int NUM_COMMITS   = NUM_RANDOM + 4; // every press could be a star
    localparam int PRESS_CYCLES  = 22 + SCAN_CYCLES; // longest press plus its sweep
    localparam int COMMIT_CYCLES = 2 * SCAN_CYCLES + 16;
    localparam int MAX_CYCLES    = NUM_PRESSES * PRESS_CYCLES
                                 + NUM_COMMITS * COMMIT_CYCLES + 200;

    logic        clk;
    logic        rst;
    logic [11:0] keys;
    logic [7:0]  digit_sel;
    seg_t        seg_data;

    logic [31:0]               lfsr_state;
    int                        cycle_count;
    int                        pass_count;
    int                        fail_count;
    frame_t                    model_work;
    frame_t                    model_shown;
    int                        model_cursor;
    seg_t                      swept [`KD_NUM_DIGITS];
    logic [`KD_NUM_DIGITS-1:0] swept_mask;

    keypad_display_top DUT (
        .clk       (clk),
        .rst       (rst),
        .keys      (keys),
        .digit_sel (digit_sel),
        .seg_data  (seg_data)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the run went past %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int nbits, output int value);
        value = 0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    function automatic key_code_t fold_key(input int v);
        if (v < 12) begin
            return key_code_t'(v);
        end else if (v < 14) begin
            return KEY_STAR; // extra weight on commits
        end else if (v == 14) begin
            return KEY_HASH;
        end
        return 4'd9;
    endfunction

    function automatic seg_t segments_for(input key_code_t code);
        case (code)
            4'd0:    return 7'b0110000;
            4'd1:    return 7'b1101101;
            4'd2:    return 7'b1111001;
            4'd3:    return 7'b0110011;
            4'd4:    return 7'b1011011;
            4'd5:    return 7'b1011111;
            4'd6:    return 7'b1110010;
            4'd7:    return 7'b1111111;
            4'd8:    return 7'b1111011;
            4'd9:    return 7'b1111110;
            default: return 7'b0000000;
        endcase
    endfunction

    task automatic apply_key(input key_code_t code);
        if (code < KEY_STAR) begin
            model_work[model_cursor] = segments_for(code);
        end else if (code == KEY_HASH) begin
            model_cursor = (model_cursor + 1) % `KD_NUM_DIGITS;
        end else begin
            model_shown = model_work;
        end
    endtask

    task automatic check_seg(input seg_t expected, input seg_t actual, input int digit);
        if (actual !== expected) begin
            $display("FAIL %0t: digit %0d shows %b, expected %b",
                     $time, digit, actual, expected);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_sel(input logic [7:0] expected, input logic [7:0] actual);
        if (actual !== expected) begin
            $display("FAIL %0t: digit_sel is %b, expected %b", $time, actual, expected);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    // starts and returns on a falling edge
    task automatic press_key(input key_code_t code, input int hold, input int gap);
        keys = 12'd1 << code;
        repeat (hold) @(negedge clk);
        keys = '0;
        repeat (gap) @(negedge clk);
    endtask

    task automatic press_chord(input key_code_t a, input key_code_t b,
                               input int hold, input int gap);
        keys = (12'd1 << a) | (12'd1 << b);
        repeat (hold) @(negedge clk);
        keys = '0;
        repeat (gap) @(negedge clk);
    endtask

    task automatic wait_settle();
        repeat (SETTLE_CYCLES) @(negedge clk);
    endtask

    // every digit shows up at least once in a full scan period
    task automatic sweep_and_compare();
        swept_mask = '0;
        for (int i = 0; i < SCAN_CYCLES; i++) begin
            for (int d = 0; d < `KD_NUM_DIGITS; d++) begin
                if (digit_sel[d]) begin
                    swept[d]      = seg_data;
                    swept_mask[d] = 1'b1;
                end
            end
            @(negedge clk);
        end
        for (int d = 0; d < `KD_NUM_DIGITS; d++) begin
            if (!swept_mask[d]) begin
                $display("digit %0d was never selected during a full scan", d);
                fail_count++;
            end else begin
                check_seg(model_shown[d], swept[d], d);
            end
        end
    endtask

    task automatic report_test(input string name, input int start);
        if (fail_count == start) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, fail_count - start);
        end
    endtask

    task automatic reset_blank_display();
        int start;
        start = fail_count;
        for (int i = 0; i < `KD_SCAN_DIVIDE; i++) begin
            check_sel(8'h00, digit_sel);
            @(negedge clk);
        end
        wait_settle();
        sweep_and_compare(); // committed frame still blank
        report_test("reset", start);
    endtask

    task automatic scan_order_sweep();
        int         start;
        logic [7:0] prev_sel;
        start    = fail_count;
        prev_sel = digit_sel;
        @(negedge clk);
        while (!(digit_sel == 8'h01 && prev_sel != 8'h01)) begin
            prev_sel = digit_sel;
            @(negedge clk);
        end
        for (int k = 0; k < 2 * `KD_NUM_DIGITS; k++) begin
            for (int j = 0; j < `KD_SCAN_DIVIDE; j++) begin
                check_sel(8'd1 << (k % `KD_NUM_DIGITS), digit_sel);
                @(negedge clk);
            end
        end
        report_test("scan order", start);
    endtask

    task automatic random_key_entry();
        int        start;
        int        v;
        int        hold;
        int        gap;
        int        chord;
        key_code_t code;
        start = fail_count;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            random_bits(4, v);
            random_bits(3, hold);
            random_bits(3, gap);
            random_bits(3, chord);
            code = fold_key(v);
            if (chord == 0) begin
                press_chord(code, key_code_t'((code + 5) % 12), 4 + hold, 4 + gap);
            end else begin
                apply_key(code);
                press_key(code, 4 + hold, 4 + gap);
                if (code == KEY_STAR) begin
                    wait_settle();
                end
            end
            sweep_and_compare();
        end
        report_test("digit entry", start);
    endtask

    task automatic cursor_wraparound();
        int start;
        start = fail_count;
        while (model_cursor != `KD_NUM_DIGITS - 1) begin
            apply_key(KEY_HASH);
            press_key(KEY_HASH, 5, 5);
        end
        // the ninth digit lands back in slot 0
        for (int k = 0; k <= `KD_NUM_DIGITS; k++) begin
            apply_key(KEY_HASH);
            press_key(KEY_HASH, 5, 5);
            apply_key(key_code_t'(k));
            press_key(key_code_t'(k), 5, 5);
        end
        apply_key(KEY_STAR);
        press_key(KEY_STAR, 5, 5);
        wait_settle();
        sweep_and_compare();
        if (swept_mask[0] && swept_mask[1] && swept_mask[7]) begin
            check_seg(7'b1111011, swept[0], 0); // nine
            check_seg(7'b1101101, swept[1], 1); // two
            check_seg(7'b1111111, swept[7], 7); // eight
        end
        report_test("cursor wrap", start);
    endtask

    task automatic held_and_chord_keys();
        int start;
        start = fail_count;
        apply_key(KEY_HASH);
        press_key(KEY_HASH, 40, 6); // long hold steps only once
        apply_key(4'd4);
        press_key(4'd4, 6, 6);
        press_chord(4'd1, 4'd7, 8, 6); // no event expected
        apply_key(KEY_STAR);
        press_key(KEY_STAR, 6, 6);
        wait_settle();
        sweep_and_compare();
        report_test("press cleanliness", start);
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b0;
        keys         = '0;
        lfsr_state   = 32'h3ba817ae;
        cycle_count  = 0;
        pass_count   = 0;
        fail_count   = 0;
        model_work   = '0;
        model_shown  = '0;
        model_cursor = 0;
        swept_mask   = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        reset_blank_display();
        scan_order_sweep();
        random_key_entry();
        cursor_wraparound();
        held_and_chord_keys();

        $display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
